//--- include/rob_defines.svh
// reorder buffer sizing and instruction-kind codes
// shared by the package and every RTL block of the buffer
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// ==============================
// sizing
// ==============================
`define ROB_DEPTH     16
`define DECODE_WIDTH  2
// commit masks assume exactly two slots
`define COMMIT_WIDTH  2

// ==============================
// instruction kinds
// ==============================
`define KIND_ALU    3'd0
`define KIND_BR     3'd1
`define KIND_LOAD   3'd2
`define KIND_STORE  3'd3
`define KIND_PRIV   3'd4

`endif

//--- rtl/rob_pkg.sv
// reorder buffer types
// vector typedefs for indices, pointers, addresses and kinds
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

  // entry index into the buffer
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

  // index with the position bit on top, tells full from empty
  typedef logic [$clog2(`ROB_DEPTH):0] rob_ptr_t;

  // occupancy 0..depth, same width as a pointer
  typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

  // instruction address, also the redirect target
  typedef logic [31:0] pc_t;

  // instruction kind, see KIND_* codes
  typedef logic [2:0] kind_t;

endpackage

`default_nettype wire

//--- rtl/rob_alloc.sv
// reorder buffer allocation side
// owns the tail pointer, checks free space and hands out
// one entry index and position bit per decode slot
`default_nettype none

`include "rob_defines.svh"

module rob_alloc import rob_pkg::*; (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            flush,
  input  wire logic [`DECODE_WIDTH-1:0]        alloc_valid,
  input  wire logic                            alloc_go,
  input  rob_ptr_t                             head_ptr,
  output logic                                 alloc_ready,
  output logic [`DECODE_WIDTH-1:0]             alloc_we,
  output rob_idx_t [`DECODE_WIDTH-1:0]         alloc_idx,
  output logic [`DECODE_WIDTH-1:0]             alloc_pos,
  output rob_ptr_t                             tail_ptr
);

  localparam int IDX_W = $bits(rob_idx_t);
  localparam int CNT_W = $clog2(`DECODE_WIDTH) + 1;

  rob_cnt_t                      occupancy;
  rob_ptr_t [`DECODE_WIDTH-1:0]  alloc_ptr;
  logic [CNT_W-1:0]              alloc_cnt;
  logic                          alloc_fire;

  // pointers carry the position bit so plain subtraction wraps right
  assign occupancy   = tail_ptr - head_ptr;
  // room for a full decode group
  assign alloc_ready = occupancy <= rob_cnt_t'(`ROB_DEPTH - `DECODE_WIDTH);
  assign alloc_fire  = alloc_ready & alloc_go & ~flush;

  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_ptr[i] = tail_ptr + rob_ptr_t'(i);
      alloc_idx[i] = alloc_ptr[i][IDX_W-1:0];
      alloc_pos[i] = alloc_ptr[i][IDX_W];
      alloc_we[i]  = alloc_fire & alloc_valid[i];
      // valid slots are packed from slot 0
      alloc_cnt    = alloc_cnt + CNT_W'(alloc_valid[i]);
    end
  end

  // ==============================
  // tail pointer
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_ptr <= '0;
    end else if (flush) begin
      tail_ptr <= '0;
    end else if (alloc_fire) begin
      tail_ptr <= tail_ptr + rob_ptr_t'(alloc_cnt);
    end
  end

endmodule

`default_nettype wire

//--- rtl/rob_core.sv
// reorder buffer entry storage
// writes entries at allocation, marks completion from two ALU
// writeback ports and one memory port, and reads the two
// entries at the head for the commit side
// non-load memory writebacks wait until their entry is oldest
`default_nettype none

`include "rob_defines.svh"

module rob_core import rob_pkg::*; #(
  parameter int ALU_PORTS = 2
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  // allocation writes
  input  wire logic [`DECODE_WIDTH-1:0]    alloc_we,
  input  rob_idx_t [`DECODE_WIDTH-1:0]     alloc_idx,
  input  pc_t [`DECODE_WIDTH-1:0]          alloc_pc,
  input  kind_t [`DECODE_WIDTH-1:0]        alloc_kind,
  input  wire logic [`DECODE_WIDTH-1:0]    alloc_excp,
  // ALU writeback
  input  wire logic [ALU_PORTS-1:0]        alu_wb_valid,
  input  rob_idx_t [ALU_PORTS-1:0]         alu_wb_idx,
  input  wire logic [ALU_PORTS-1:0]        alu_wb_redirect,
  input  pc_t [ALU_PORTS-1:0]              alu_wb_target,
  // memory writeback
  input  wire logic                        mem_wb_valid,
  input  rob_idx_t                         mem_wb_idx,
  input  wire logic                        mem_wb_load,
  input  wire logic                        mem_wb_excp,
  output logic                             mem_wb_ready,
  // head read
  input  rob_ptr_t                         head_ptr,
  output logic [`COMMIT_WIDTH-1:0]         rd_complete,
  output kind_t [`COMMIT_WIDTH-1:0]        rd_kind,
  output pc_t [`COMMIT_WIDTH-1:0]          rd_pc,
  output logic [`COMMIT_WIDTH-1:0]         rd_excp,
  output logic [`COMMIT_WIDTH-1:0]         rd_redirect,
  output pc_t [`COMMIT_WIDTH-1:0]          rd_target
);

  localparam int IDX_W = $bits(rob_idx_t);

  // completion flags
  logic [`ROB_DEPTH-1:0] complete_q;
  // entry payload
  pc_t                   pc_q     [`ROB_DEPTH];
  kind_t                 kind_q   [`ROB_DEPTH];
  pc_t                   target_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] excp_q;
  logic [`ROB_DEPTH-1:0] redirect_q;

  rob_idx_t                      head_idx;
  rob_idx_t [`COMMIT_WIDTH-1:0]  rd_idx;
  logic                          mem_wb_fire;

  assign head_idx = head_ptr[IDX_W-1:0];

  // ==============================
  // memory ordering
  // ==============================
  // plain loads go any time, stores and the rest only at the head
  assign mem_wb_ready = mem_wb_load | (mem_wb_idx == head_idx);
  assign mem_wb_fire  = mem_wb_valid & mem_wb_ready;

  // ==============================
  // completion
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      complete_q <= '0;
    end else begin
      // an exception at allocation counts as done
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        if (alloc_we[i]) begin
          complete_q[alloc_idx[i]] <= alloc_excp[i];
        end
      end
      for (int i = 0; i < ALU_PORTS; i++) begin
        if (alu_wb_valid[i]) begin
          complete_q[alu_wb_idx[i]] <= 1'b1;
        end
      end
      if (mem_wb_fire) begin
        complete_q[mem_wb_idx] <= 1'b1;
      end
    end
  end

  // ==============================
  // payload
  // ==============================
  always_ff @(posedge clk) begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      if (alloc_we[i]) begin
        pc_q[alloc_idx[i]]       <= alloc_pc[i];
        kind_q[alloc_idx[i]]     <= alloc_kind[i];
        excp_q[alloc_idx[i]]     <= alloc_excp[i];
        // no redirect until an ALU says so
        redirect_q[alloc_idx[i]] <= 1'b0;
      end
    end
    for (int i = 0; i < ALU_PORTS; i++) begin
      if (alu_wb_valid[i]) begin
        redirect_q[alu_wb_idx[i]] <= alu_wb_redirect[i];
        target_q[alu_wb_idx[i]]   <= alu_wb_target[i];
      end
    end
    if (mem_wb_fire) begin
      excp_q[mem_wb_idx] <= mem_wb_excp;
    end
  end

  // head and head+1, index wraps on its own
  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      rd_idx[i]      = head_idx + rob_idx_t'(i);
      rd_complete[i] = complete_q[rd_idx[i]];
      rd_kind[i]     = kind_q[rd_idx[i]];
      rd_pc[i]       = pc_q[rd_idx[i]];
      rd_excp[i]     = excp_q[rd_idx[i]];
      rd_redirect[i] = redirect_q[rd_idx[i]];
      rd_target[i]   = target_q[rd_idx[i]];
    end
  end

endmodule

`default_nettype wire

//--- rtl/rob_commit.sv
// reorder buffer commit side
// owns the head pointer, retires up to two entries in order
// second slot is held back behind a branch, a privileged op,
// a redirect or an exception
`default_nettype none

`include "rob_defines.svh"

module rob_commit import rob_pkg::*; (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        flush,
  input  rob_ptr_t                         tail_ptr,
  input  wire logic [`COMMIT_WIDTH-1:0]    rd_complete,
  input  kind_t [`COMMIT_WIDTH-1:0]        rd_kind,
  input  pc_t [`COMMIT_WIDTH-1:0]          rd_pc,
  input  wire logic [`COMMIT_WIDTH-1:0]    rd_excp,
  input  wire logic [`COMMIT_WIDTH-1:0]    rd_redirect,
  input  pc_t [`COMMIT_WIDTH-1:0]          rd_target,
  output rob_ptr_t                         head_ptr,
  output logic [`COMMIT_WIDTH-1:0]         cmt_valid,
  output pc_t [`COMMIT_WIDTH-1:0]          cmt_pc,
  output logic [`COMMIT_WIDTH-1:0]         cmt_excp,
  output logic [`COMMIT_WIDTH-1:0]         cmt_redirect,
  output pc_t [`COMMIT_WIDTH-1:0]          cmt_target
);

  localparam int CNT_W = $clog2(`COMMIT_WIDTH) + 1;

  rob_cnt_t                  occupancy;
  logic [`COMMIT_WIDTH-1:0]  valid_mask;
  logic [`COMMIT_WIDTH-1:0]  redirect_mask;
  logic [`COMMIT_WIDTH-1:0]  exc_mask;
  logic [`COMMIT_WIDTH-1:0]  br_mask;
  logic [`COMMIT_WIDTH-1:0]  priv_mask;
  logic [`COMMIT_WIDTH-1:0]  commit_mask;
  logic [CNT_W-1:0]          cmt_cnt;

  assign occupancy = tail_ptr - head_ptr;

  // ==============================
  // dual-commit masks
  // ==============================
  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      valid_mask[i] = occupancy > rob_cnt_t'(i);
    end
    // slot 0 is never masked
    redirect_mask[0] = 1'b1;
    exc_mask[0]      = 1'b1;
    br_mask[0]       = 1'b1;
    priv_mask[0]     = 1'b1;
    // redirect or exception must drain alone
    redirect_mask[1] = ~rd_redirect[0] & ~rd_redirect[1];
    exc_mask[1]      = ~rd_excp[0] & ~rd_excp[1];
    // one branch per cycle, nothing behind a privileged op
    br_mask[1]       = rd_kind[0] != `KIND_BR;
    priv_mask[1]     = rd_kind[0] != `KIND_PRIV;
    commit_mask      = redirect_mask & exc_mask & br_mask & priv_mask;

    cmt_valid[0] = valid_mask[0] & rd_complete[0] & commit_mask[0];
    cmt_valid[1] = cmt_valid[0] & valid_mask[1] & rd_complete[1] & commit_mask[1];
    cmt_cnt      = CNT_W'(cmt_valid[0]) + CNT_W'(cmt_valid[1]);
  end

  assign cmt_pc       = rd_pc;
  assign cmt_excp     = rd_excp;
  assign cmt_redirect = rd_redirect;
  assign cmt_target   = rd_target;

  // ==============================
  // head pointer
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
    end else if (flush) begin
      head_ptr <= '0;
    end else begin
      head_ptr <= head_ptr + rob_ptr_t'(cmt_cnt);
    end
  end

endmodule

`default_nettype wire

//--- rtl/rob_top.sv
// reorder buffer top level
// allocation side, entry storage and commit side joined by
// the head and tail pointers and the head read fields
`default_nettype none

`include "rob_defines.svh"

module rob_top import rob_pkg::*; (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        flush,
  // allocation
  input  wire logic [`DECODE_WIDTH-1:0]    alloc_valid,
  input  wire logic                        alloc_go,
  input  pc_t [`DECODE_WIDTH-1:0]          alloc_pc,
  input  kind_t [`DECODE_WIDTH-1:0]        alloc_kind,
  input  wire logic [`DECODE_WIDTH-1:0]    alloc_excp,
  output logic                             alloc_ready,
  output rob_idx_t [`DECODE_WIDTH-1:0]     alloc_idx,
  output logic [`DECODE_WIDTH-1:0]         alloc_pos,
  // ALU writeback
  input  wire logic [1:0]                  alu_wb_valid,
  input  rob_idx_t [1:0]                   alu_wb_idx,
  input  wire logic [1:0]                  alu_wb_redirect,
  input  pc_t [1:0]                        alu_wb_target,
  // memory writeback
  input  wire logic                        mem_wb_valid,
  input  rob_idx_t                         mem_wb_idx,
  input  wire logic                        mem_wb_load,
  input  wire logic                        mem_wb_excp,
  output logic                             mem_wb_ready,
  // commit
  output logic [`COMMIT_WIDTH-1:0]         cmt_valid,
  output pc_t [`COMMIT_WIDTH-1:0]          cmt_pc,
  output logic [`COMMIT_WIDTH-1:0]         cmt_excp,
  output logic [`COMMIT_WIDTH-1:0]         cmt_redirect,
  output pc_t [`COMMIT_WIDTH-1:0]          cmt_target
);

  rob_ptr_t                          head_ptr;
  rob_ptr_t                          tail_ptr;
  logic [`DECODE_WIDTH-1:0]          alloc_we;
  // head entry fields
  logic [`COMMIT_WIDTH-1:0]          rd_complete;
  kind_t [`COMMIT_WIDTH-1:0]         rd_kind;
  pc_t [`COMMIT_WIDTH-1:0]           rd_pc;
  logic [`COMMIT_WIDTH-1:0]          rd_excp;
  logic [`COMMIT_WIDTH-1:0]          rd_redirect;
  pc_t [`COMMIT_WIDTH-1:0]           rd_target;

  rob_alloc u_alloc (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .alloc_valid (alloc_valid),
    .alloc_go    (alloc_go),
    .head_ptr    (head_ptr),
    .alloc_ready (alloc_ready),
    .alloc_we    (alloc_we),
    .alloc_idx   (alloc_idx),
    .alloc_pos   (alloc_pos),
    .tail_ptr    (tail_ptr)
  );

  rob_core u_core (
    .clk             (clk),
    .rst_n           (rst_n),
    .alloc_we        (alloc_we),
    .alloc_idx       (alloc_idx),
    .alloc_pc        (alloc_pc),
    .alloc_kind      (alloc_kind),
    .alloc_excp      (alloc_excp),
    .alu_wb_valid    (alu_wb_valid),
    .alu_wb_idx      (alu_wb_idx),
    .alu_wb_redirect (alu_wb_redirect),
    .alu_wb_target   (alu_wb_target),
    .mem_wb_valid    (mem_wb_valid),
    .mem_wb_idx      (mem_wb_idx),
    .mem_wb_load     (mem_wb_load),
    .mem_wb_excp     (mem_wb_excp),
    .mem_wb_ready    (mem_wb_ready),
    .head_ptr        (head_ptr),
    .rd_complete     (rd_complete),
    .rd_kind         (rd_kind),
    .rd_pc           (rd_pc),
    .rd_excp         (rd_excp),
    .rd_redirect     (rd_redirect),
    .rd_target       (rd_target)
  );

  rob_commit u_commit (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .tail_ptr     (tail_ptr),
    .rd_complete  (rd_complete),
    .rd_kind      (rd_kind),
    .rd_pc        (rd_pc),
    .rd_excp      (rd_excp),
    .rd_redirect  (rd_redirect),
    .rd_target    (rd_target),
    .head_ptr     (head_ptr),
    .cmt_valid    (cmt_valid),
    .cmt_pc       (cmt_pc),
    .cmt_excp     (cmt_excp),
    .cmt_redirect (cmt_redirect),
    .cmt_target   (cmt_target)
  );

endmodule

`default_nettype wire

//--- sim/rob_asserts.sv
// reorder buffer protocol checks, bound to the top level
// quiet commit outputs in reset and after a flush, free
// space right after a flush
`default_nettype none

`include "rob_defines.svh"

module rob_asserts (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        flush,
  input  wire logic                        alloc_ready,
  input  wire logic [`COMMIT_WIDTH-1:0]    cmt_valid
);

  // number of failed assertions
  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // an emptied buffer has nothing to retire
  flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> cmt_valid == '0)
    else begin
      fail_cnt++;
      $error("cmt_valid high in the cycle after a flush");
    end

  // nothing retires while in reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> cmt_valid == '0)
    else begin
      fail_cnt++;
      $error("cmt_valid high during reset");
    end

  // empty buffer after flush has room
  flush_ready: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> alloc_ready)
    else begin
      fail_cnt++;
      $error("alloc_ready low in the cycle after a flush");
    end

endmodule

`default_nettype wire

//--- sim/tb_rob.sv
// reorder buffer testbench
// random allocation and out-of-order writeback against an
// in-order reference queue, then a fill without writeback
// and a flush; commit and ready outputs checked every cycle
`default_nettype none

`include "rob_defines.svh"

module tb_rob import rob_pkg::*; ();

  logic                              clk;
  logic                              rst_n;
  logic                              flush;
  logic [`DECODE_WIDTH-1:0]          alloc_valid;
  logic                              alloc_go;
  pc_t [`DECODE_WIDTH-1:0]           alloc_pc;
  kind_t [`DECODE_WIDTH-1:0]         alloc_kind;
  logic [`DECODE_WIDTH-1:0]          alloc_excp;
  logic                              alloc_ready;
  rob_idx_t [`DECODE_WIDTH-1:0]      alloc_idx;
  logic [`DECODE_WIDTH-1:0]          alloc_pos;
  logic [1:0]                        alu_wb_valid;
  rob_idx_t [1:0]                    alu_wb_idx;
  logic [1:0]                        alu_wb_redirect;
  pc_t [1:0]                         alu_wb_target;
  logic                              mem_wb_valid;
  rob_idx_t                          mem_wb_idx;
  logic                              mem_wb_load;
  logic                              mem_wb_excp;
  logic                              mem_wb_ready;
  logic [`COMMIT_WIDTH-1:0]          cmt_valid;
  pc_t [`COMMIT_WIDTH-1:0]           cmt_pc;
  logic [`COMMIT_WIDTH-1:0]          cmt_excp;
  logic [`COMMIT_WIDTH-1:0]          cmt_redirect;
  pc_t [`COMMIT_WIDTH-1:0]           cmt_target;

  // ==============================
  // reference model
  // ==============================
  pc_t                   m_pc     [`ROB_DEPTH];
  kind_t                 m_kind   [`ROB_DEPTH];
  pc_t                   m_target [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] m_excp;
  logic [`ROB_DEPTH-1:0] m_redir;
  logic [`ROB_DEPTH-1:0] m_done;
  // entries in program order, and those still waiting for writeback
  rob_idx_t              order_q  [$];
  rob_idx_t              alu_pend [$];
  rob_idx_t              mem_pend [$];
  rob_idx_t              tail_m;
  // flips each time the tail wraps past the last entry
  logic                  pos_m;
  int unsigned           errors;

  rob_top i_dut (.*);

  bind rob_top rob_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .alloc_ready (alloc_ready),
    .cmt_valid   (cmt_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic kind_t random_kind();
    case ($urandom_range(7))
      3: return `KIND_BR;
      4: return `KIND_LOAD;
      5: return `KIND_STORE;
      6: return `KIND_PRIV;
      default: return `KIND_ALU;
    endcase
  endfunction

  task automatic drive_alloc(input bit with_excp);
    alloc_go    = 1'b1;
    alloc_valid = ($urandom_range(3) == 0) ? 2'b01 : 2'b11;
    for (int s = 0; s < `DECODE_WIDTH; s++) begin
      alloc_pc[s]   = $urandom & 32'hffff_fffc;
      alloc_kind[s] = random_kind();
      alloc_excp[s] = with_excp && ($urandom_range(7) == 0);
    end
  endtask

  // ALU entries complete in random order, memory entries in order
  task automatic drive_wb();
    int unsigned k;
    rob_idx_t    idx;
    for (int p = 0; p < 2; p++) begin
      if (alu_pend.size() > 0 && $urandom_range(1) == 1) begin
        k   = $urandom_range(alu_pend.size() - 1);
        idx = alu_pend[k];
        alu_pend.delete(k);
        alu_wb_valid[p]    = 1'b1;
        alu_wb_idx[p]      = idx;
        alu_wb_redirect[p] = (m_kind[idx] == `KIND_BR) && ($urandom_range(2) == 0);
        alu_wb_target[p]   = $urandom & 32'hffff_fffc;
      end
    end
    // a store not at the head stays on the port until accepted
    if (!mem_wb_valid && mem_pend.size() > 0 && $urandom_range(1) == 1) begin
      idx          = mem_pend.pop_front();
      mem_wb_valid = 1'b1;
      mem_wb_idx   = idx;
      mem_wb_load  = (m_kind[idx] == `KIND_LOAD);
      mem_wb_excp  = ($urandom_range(5) == 0);
    end
  endtask

  task automatic record_alloc();
    for (int s = 0; s < `DECODE_WIDTH; s++) begin
      if (alloc_valid[s]) begin
        m_pc[tail_m]   = alloc_pc[s];
        m_kind[tail_m] = alloc_kind[s];
        m_excp[tail_m] = alloc_excp[s];
        m_done[tail_m] = alloc_excp[s];
        m_redir[tail_m] = 1'b0;
        order_q.push_back(tail_m);
        if (!alloc_excp[s]) begin
          if (alloc_kind[s] == `KIND_LOAD || alloc_kind[s] == `KIND_STORE) begin
            mem_pend.push_back(tail_m);
          end else begin
            alu_pend.push_back(tail_m);
          end
        end
        tail_m++;
        if (tail_m == '0) begin
          pos_m = ~pos_m;
        end
      end
    end
  endtask

  task automatic retire_slot(input int s);
    rob_idx_t idx;
    idx = order_q.pop_front();
    expect_eq($sformatf("cmt_pc[%0d]", s), cmt_pc[s], m_pc[idx]);
    expect_eq($sformatf("cmt_excp[%0d]", s), 32'(cmt_excp[s]), 32'(m_excp[idx]));
    expect_eq($sformatf("cmt_redirect[%0d]", s), 32'(cmt_redirect[s]), 32'(m_redir[idx]));
    if (m_redir[idx]) begin
      expect_eq($sformatf("cmt_target[%0d]", s), cmt_target[s], m_target[idx]);
    end
  endtask

  // ==============================
  // one clock cycle
  // ==============================
  // check at the falling edge, update the model, then release
  // one-shot inputs just after the rising edge
  task automatic cycle();
    logic     exp0;
    logic     exp1;
    logic     mem_fired;
    rob_idx_t h0;
    rob_idx_t h1;
    @(negedge clk);
    h0   = (order_q.size() > 0) ? order_q[0] : '0;
    h1   = (order_q.size() > 1) ? order_q[1] : '0;
    exp0 = order_q.size() > 0 && m_done[h0];
    exp1 = exp0 && order_q.size() > 1 && m_done[h1] && !m_excp[h0] && !m_excp[h1]
           && !m_redir[h0] && !m_redir[h1]
           && m_kind[h0] != `KIND_BR && m_kind[h0] != `KIND_PRIV;
    expect_eq("cmt_valid", 32'(cmt_valid), 32'({exp1, exp0}));
    expect_eq("alloc_ready", 32'(alloc_ready), 32'(order_q.size() <= `ROB_DEPTH - 2));
    expect_eq("alloc_idx[0]", 32'(alloc_idx[0]), 32'(tail_m));
    expect_eq("alloc_idx[1]", 32'(alloc_idx[1]), 32'(rob_idx_t'(tail_m + 1'b1)));
    expect_eq("alloc_pos[0]", 32'(alloc_pos[0]), 32'(pos_m));
    expect_eq("alloc_pos[1]", 32'(alloc_pos[1]),
              32'(pos_m ^ (tail_m == rob_idx_t'(`ROB_DEPTH - 1))));
    mem_fired = mem_wb_valid && mem_wb_ready;
    if (mem_wb_valid) begin
      expect_eq("mem_wb_ready", 32'(mem_wb_ready),
                32'(mem_wb_load || (order_q.size() > 0 && mem_wb_idx == h0)));
    end
    for (int s = 0; s < `COMMIT_WIDTH; s++) begin
      if (cmt_valid[s] && order_q.size() > 0) begin
        retire_slot(s);
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (alu_wb_valid[p]) begin
        m_done[alu_wb_idx[p]]   = 1'b1;
        m_redir[alu_wb_idx[p]]  = alu_wb_redirect[p];
        m_target[alu_wb_idx[p]] = alu_wb_target[p];
      end
    end
    if (mem_fired) begin
      m_done[mem_wb_idx] = 1'b1;
      m_excp[mem_wb_idx] = mem_wb_excp;
    end
    if (flush) begin
      order_q.delete();
      alu_pend.delete();
      mem_pend.delete();
      tail_m = '0;
      pos_m  = 1'b0;
    end else if (alloc_go && alloc_ready) begin
      record_alloc();
    end
    @(posedge clk);
    #1;
    alloc_go     = 1'b0;
    alloc_valid  = '0;
    alu_wb_valid = '0;
    flush        = 1'b0;
    if (mem_fired) begin
      mem_wb_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int unsigned n;
    n = 0;
    while (order_q.size() > 0 && n < 300) begin
      drive_wb();
      cycle();
      n++;
    end
    if (order_q.size() > 0) begin
      errors++;
      $display("timeout: buffer did not drain, %0d entries left", order_q.size());
    end
  endtask

  initial begin
    int unsigned n;
    void'($urandom(32'h5c7088d3));
    errors          = 0;
    tail_m          = '0;
    pos_m           = 1'b0;
    rst_n           = 1'b0;
    flush           = 1'b0;
    alloc_valid     = '0;
    alloc_go        = 1'b0;
    alloc_pc        = '0;
    alloc_kind      = '0;
    alloc_excp      = '0;
    alu_wb_valid    = '0;
    alu_wb_idx      = '0;
    alu_wb_redirect = '0;
    alu_wb_target   = '0;
    mem_wb_valid    = 1'b0;
    mem_wb_idx      = '0;
    mem_wb_load     = 1'b0;
    mem_wb_excp     = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    // mixed traffic with completions out of order
    for (int i = 0; i < 400; i++) begin
      if ($urandom_range(3) != 0) begin
        drive_alloc(1'b1);
      end
      drive_wb();
      cycle();
    end
    drain();

    // fill until alloc_ready drops, hold decode a while, then release
    n = 0;
    while (order_q.size() <= `ROB_DEPTH - 2 && n < 40) begin
      drive_alloc(1'b0);
      cycle();
      n++;
    end
    if (n >= 40) begin
      errors++;
      $display("timeout: buffer never reported full");
    end
    repeat (3) begin
      drive_alloc(1'b0);
      cycle();
    end
    drain();

    // flush with entries in flight
    repeat (3) begin
      drive_alloc(1'b0);
      cycle();
    end
    flush = 1'b1;
    cycle();
    repeat (3) cycle();
    drive_alloc(1'b1);
    cycle();
    drain();

    $display("check errors: %0d, assertion failures: %0d", errors, i_dut.u_asserts.fail_cnt);
    if (errors == 0 && i_dut.u_asserts.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_core.sv
rtl/rob_commit.sv
rtl/rob_top.sv
sim/rob_asserts.sv
sim/tb_rob.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_rob
FILELIST := tb.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
